/* design/fifo_pkg.sv */
// Pointer helpers work on pointers of up to 32 bits; callers zero-extend and truncate to fit
package fifo_pkg;

    // --------------------------------------------------
    // Default sizes for the FIFO top level
    // --------------------------------------------------

    // Entry count, must stay a power of two
    localparam int DEFAULT_DEPTH      = 16;
    localparam int DEFAULT_DATA_WIDTH = 8;

    // Pointer synchronizer depth
    localparam int DEFAULT_N_SYNC     = 2;
    // Fewer than two stages gives no settling time
    localparam int MIN_N_SYNC         = 2;

    // Working width of the conversion functions
    localparam int PTR_FN_W           = 32;

    // --------------------------------------------------
    // Binary and Gray conversions
    // --------------------------------------------------

    // Adjacent binary values map to codes that differ in one bit
    function automatic logic [PTR_FN_W-1:0] bin_to_gray(input logic [PTR_FN_W-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at and above it
    function automatic logic [PTR_FN_W-1:0] gray_to_bin(input logic [PTR_FN_W-1:0] gray);
        logic [PTR_FN_W-1:0] bin;
        bin[PTR_FN_W-1] = gray[PTR_FN_W-1];
        // Walk down from the MSB
        for (int i = PTR_FN_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage : fifo_pkg

/* design/ptr_counter.sv */
// Wraps at 2**PTR_W; the extra MSB over the address width separates full from empty
`timescale 1ns/10ps

module ptr_counter
    import fifo_pkg::*;
#(
    // Address bits plus one wrap bit
    parameter int PTR_W = $clog2(DEFAULT_DEPTH) + 1
) (
    input  logic             wr_clk,
    input  logic             rd_rst_n,
    input  logic             i_inc,
    output logic [PTR_W-1:0] o_bin,
    output logic [PTR_W-1:0] o_bin_next,
    output logic [PTR_W-1:0] o_gray
);

    // --------------------------------------------------
    // Next pointer
    // --------------------------------------------------

    // Value the counter holds after this edge
    always_comb begin
        o_bin_next = i_inc ? o_bin + 1'b1 : o_bin;
    end

    // --------------------------------------------------
    // Pointer registers
    // --------------------------------------------------

    // Binary copy addresses the storage
    always_ff @(posedge wr_clk) begin
        if (!rd_rst_n) begin
            o_bin <= '0;
        end else begin
            o_bin <= o_bin_next;
        end
    end

    // Gray copy feeds the synchronizer
    // Registered from the next value so both copies move on the same edge
    always_ff @(posedge wr_clk) begin
        if (!rd_rst_n) begin
            o_gray <= '0;
        end else begin
            o_gray <= PTR_W'(bin_to_gray(PTR_FN_W'(o_bin_next)));
        end
    end

endmodule : ptr_counter

/* design/ptr_sync.sv */
// Input must be Gray coded so at most one bit changes between edges; latency is N_SYNC edges
`timescale 1ns/10ps

module ptr_sync
    import fifo_pkg::*;
#(
    parameter int PTR_W  = $clog2(DEFAULT_DEPTH) + 1,
    // Register stages in the crossing
    parameter int N_SYNC = DEFAULT_N_SYNC
) (
    input  logic             wr_clk,
    input  logic             rd_rst_n,
    input  logic [PTR_W-1:0] i_gray,
    output logic [PTR_W-1:0] o_bin
);

    // --------------------------------------------------
    // Synchronizer chain
    // --------------------------------------------------

    // Stage 0 samples the remote pointer
    logic [PTR_W-1:0] sync_q [N_SYNC];

    always_ff @(posedge wr_clk) begin
        if (!rd_rst_n) begin
            // Matches the reset value of the source counter
            for (int i = 0; i < N_SYNC; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= i_gray;
            // Shift toward the last stage
            for (int i = 1; i < N_SYNC; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // --------------------------------------------------
    // Back to binary
    // --------------------------------------------------

    // Only the settled last stage is decoded
    // A one-bit change decodes to the old or the new pointer, never between
    always_comb begin
        o_bin = PTR_W'(gray_to_bin(PTR_FN_W'(sync_q[N_SYNC-1])));
    end

endmodule : ptr_sync

/* design/fifo_flags.sv */
// DEPTH must be a power of two; remote pointers lag, so flags err toward full and toward empty
`timescale 1ns/10ps

module fifo_flags
    import fifo_pkg::*;
#(
    parameter int DEPTH     = DEFAULT_DEPTH,
    parameter int PTR_W     = $clog2(DEFAULT_DEPTH) + 1,
    // Free entries left when almost-full rises
    parameter int WR_MARGIN = 1,
    // Entries left when almost-empty rises
    parameter int RD_MARGIN = 1
) (
    input  logic             wr_clk,
    input  logic             rd_rst_n,
    input  logic [PTR_W-1:0] i_wr_bin_next,
    input  logic [PTR_W-1:0] i_wdom_rd_bin,
    input  logic [PTR_W-1:0] i_rd_bin_next,
    input  logic [PTR_W-1:0] i_rdom_wr_bin,
    output logic             o_full,
    output logic             o_almost_full,
    output logic             o_empty,
    output logic             o_almost_empty
);

    // Thresholds sized to the pointer
    localparam logic [PTR_W-1:0] FULL_LVL    = PTR_W'(DEPTH);
    localparam logic [PTR_W-1:0] AFULL_LVL   = PTR_W'(DEPTH - WR_MARGIN);
    localparam logic [PTR_W-1:0] AEMPTY_LVL  = PTR_W'(RD_MARGIN);

    logic [PTR_W-1:0] wr_dist;
    logic [PTR_W-1:0] rd_dist;

    // --------------------------------------------------
    // Pointer distances
    // --------------------------------------------------

    // Wrap-around subtraction, the wrap bit keeps 0 and DEPTH apart
    always_comb begin
        // Occupancy as seen from the write side
        wr_dist = i_wr_bin_next - i_wdom_rd_bin;
        // Occupancy as seen from the read side
        rd_dist = i_rdom_wr_bin - i_rd_bin_next;
    end

    // --------------------------------------------------
    // Write side flags
    // --------------------------------------------------

    // Next pointer means a write on this edge shows up right after it
    always_ff @(posedge wr_clk) begin
        if (!rd_rst_n) begin
            o_full        <= 1'b0;
            o_almost_full <= 1'b0;
        end else begin
            o_full        <= (wr_dist == FULL_LVL);
            o_almost_full <= (wr_dist >= AFULL_LVL);
        end
    end

    // --------------------------------------------------
    // Read side flags
    // --------------------------------------------------

    // Starts empty out of reset
    always_ff @(posedge wr_clk) begin
        if (!rd_rst_n) begin
            o_empty        <= 1'b1;
            o_almost_empty <= 1'b1;
        end else begin
            o_empty        <= (rd_dist == '0);
            o_almost_empty <= (rd_dist <= AEMPTY_LVL);
        end
    end

endmodule : fifo_flags

/* design/fifo_mem.sv */
// DEPTH must be a power of two; write and read addresses are never checked against each other
`timescale 1ns/10ps

module fifo_mem
    import fifo_pkg::*;
#(
    parameter int DEPTH      = DEFAULT_DEPTH,
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    // 0 reads through a mux, 1 adds an output register
    parameter int REGISTERED = 0,
    localparam int AW        = $clog2(DEPTH)
) (
    input  logic                  wr_clk,
    input  logic                  rd_rst_n,
    input  logic                  i_wr_en,
    input  logic [AW-1:0]         i_wr_addr,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    input  logic [AW-1:0]         i_rd_addr,
    output logic [DATA_WIDTH-1:0] o_rd_data
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------

    // Entries clear on reset so the head reads zero until the first write
    always_ff @(posedge wr_clk) begin
        if (!rd_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------

    if (REGISTERED != 0) begin : g_flop
        // Head captured every edge, a popped word stays until the next edge
        always_ff @(posedge wr_clk) begin
            if (!rd_rst_n) begin
                o_rd_data <= '0;
            end else begin
                o_rd_data <= mem[i_rd_addr];
            end
        end
    end else begin : g_mux
        // Head entry visible with no added latency
        always_comb begin
            o_rd_data = mem[i_rd_addr];
        end
    end

endmodule : fifo_mem

/* design/gray_fifo.sv */
// Both sides run on wr_clk; writes when full and reads when empty are dropped without notice
`timescale 1ns/10ps

module gray_fifo
    import fifo_pkg::*;
#(
    // Power of two only
    parameter int DEPTH      = DEFAULT_DEPTH,
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int N_SYNC     = DEFAULT_N_SYNC,
    parameter int WR_MARGIN  = 1,
    parameter int RD_MARGIN  = 1,
    parameter int REGISTERED = 0
) (
    input  logic                  wr_clk,
    input  logic                  rd_rst_n,
    // Write side
    input  logic                  i_write,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    output logic                  o_full,
    output logic                  o_almost_full,
    // Read side
    input  logic                  i_read,
    output logic [DATA_WIDTH-1:0] o_rd_data,
    output logic                  o_empty,
    output logic                  o_almost_empty
);

    localparam int AW    = $clog2(DEPTH);
    // One wrap bit above the address
    localparam int PTR_W = AW + 1;

    // Elaboration checks
    if (N_SYNC < MIN_N_SYNC) begin : g_bad_sync
        $error("gray_fifo N_SYNC below the minimum stage count");
    end
    if (DEPTH != (1 << AW)) begin : g_bad_depth
        $error("gray_fifo DEPTH is not a power of two");
    end

    logic             wr_accept;
    logic             rd_accept;
    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_next;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_next;
    logic [PTR_W-1:0] rd_gray;
    // Remote pointers after the crossing
    logic [PTR_W-1:0] rdom_wr_bin;
    logic [PTR_W-1:0] wdom_rd_bin;

    // --------------------------------------------------
    // Accept strobes and pointers
    // --------------------------------------------------

    // Flags alone decide acceptance
    assign wr_accept = i_write & ~o_full;
    assign rd_accept = i_read & ~o_empty;

    ptr_counter #(.PTR_W(PTR_W)) u_wr_ptr (
        .wr_clk     (wr_clk),
        .rd_rst_n   (rd_rst_n),
        .i_inc      (wr_accept),
        .o_bin      (wr_bin),
        .o_bin_next (wr_bin_next),
        .o_gray     (wr_gray)
    );

    ptr_counter #(.PTR_W(PTR_W)) u_rd_ptr (
        .wr_clk     (wr_clk),
        .rd_rst_n   (rd_rst_n),
        .i_inc      (rd_accept),
        .o_bin      (rd_bin),
        .o_bin_next (rd_bin_next),
        .o_gray     (rd_gray)
    );

    // --------------------------------------------------
    // Pointer crossings, one per direction
    // --------------------------------------------------

    ptr_sync #(.PTR_W(PTR_W), .N_SYNC(N_SYNC)) u_wr2rd_sync (
        .wr_clk   (wr_clk),
        .rd_rst_n (rd_rst_n),
        .i_gray   (wr_gray),
        .o_bin    (rdom_wr_bin)
    );

    ptr_sync #(.PTR_W(PTR_W), .N_SYNC(N_SYNC)) u_rd2wr_sync (
        .wr_clk   (wr_clk),
        .rd_rst_n (rd_rst_n),
        .i_gray   (rd_gray),
        .o_bin    (wdom_rd_bin)
    );

    // --------------------------------------------------
    // Flags and storage
    // --------------------------------------------------

    fifo_flags #(
        .DEPTH     (DEPTH),
        .PTR_W     (PTR_W),
        .WR_MARGIN (WR_MARGIN),
        .RD_MARGIN (RD_MARGIN)
    ) u_flags (
        .wr_clk         (wr_clk),
        .rd_rst_n       (rd_rst_n),
        .i_wr_bin_next  (wr_bin_next),
        .i_wdom_rd_bin  (wdom_rd_bin),
        .i_rd_bin_next  (rd_bin_next),
        .i_rdom_wr_bin  (rdom_wr_bin),
        .o_full         (o_full),
        .o_almost_full  (o_almost_full),
        .o_empty        (o_empty),
        .o_almost_empty (o_almost_empty)
    );

    // Addresses are the pointers without the wrap bit
    fifo_mem #(
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH),
        .REGISTERED (REGISTERED)
    ) u_mem (
        .wr_clk    (wr_clk),
        .rd_rst_n  (rd_rst_n),
        .i_wr_en   (wr_accept),
        .i_wr_addr (wr_bin[AW-1:0]),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_bin[AW-1:0]),
        .o_rd_data (o_rd_data)
    );

endmodule : gray_fifo

/* dv/gray_fifo_properties.sv */
// Flag relations only, held off during reset; holds while DEPTH exceeds N_SYNC plus one
`timescale 1ns/10ps

module gray_fifo_properties (
    input logic wr_clk,
    input logic rd_rst_n,
    input logic o_full,
    input logic o_almost_full,
    input logic o_empty,
    input logic o_almost_empty
);

    // Failed assertions, read by the testbench
    int fail_cnt = 0;

    // --------------------------------------------------
    // Flag sanity
    // --------------------------------------------------

    // Lagging pointers never make both extremes true
    a_not_full_and_empty : assert property (@(posedge wr_clk) disable iff (!rd_rst_n)
        !(o_full && o_empty))
        else begin fail_cnt++; $error("o_full and o_empty are high together"); end

    a_full_is_almost_full : assert property (@(posedge wr_clk) disable iff (!rd_rst_n)
        o_full |-> o_almost_full)
        else begin fail_cnt++; $error("o_full is high without o_almost_full"); end

    a_empty_is_almost_empty : assert property (@(posedge wr_clk) disable iff (!rd_rst_n)
        o_empty |-> o_almost_empty)
        else begin fail_cnt++; $error("o_empty is high without o_almost_empty"); end

endmodule : gray_fifo_properties

// Port names match the FIFO top level
bind gray_fifo gray_fifo_properties u_props (.*);

/* dv/gray_fifo_tb.sv */
// Single clock wr_clk; the queue model judges acceptance from the DUT flags seen before each edge
`timescale 1ns/10ps

module gray_fifo_tb;

    localparam int DEPTH      = 8;
    localparam int DATA_W     = 8;
    localparam int N_SYNC     = 2;
    localparam int WR_MARGIN  = 2;
    localparam int RD_MARGIN  = 2;
    localparam int REGISTERED = 0;

    // Phase lengths in cycles
    localparam int RST_CYC   = 8;
    localparam int RAND_CYC  = 1500;
    localparam int SETTLE    = N_SYNC + 2;
    localparam int DRAIN_MAX = 4 * DEPTH;
    localparam int LAT_MAX   = 4 * SETTLE;
    localparam int ROUNDS    = 12;
    localparam int TOTAL_CYC = RST_CYC + RAND_CYC + 5 * (DRAIN_MAX + SETTLE) + DEPTH + 4
                             + LAT_MAX + 8 + SETTLE + ROUNDS * (16 + SETTLE);
    // Right-shift Galois taps for x^32 + x^30 + x^26 + x^25 + 1
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;

    logic              wr_clk;
    logic              rd_rst_n;
    logic              i_write;
    logic [DATA_W-1:0] i_wr_data;
    logic              i_read;
    logic [DATA_W-1:0] o_rd_data;
    logic              o_full;
    logic              o_almost_full;
    logic              o_empty;
    logic              o_almost_empty;

    // Reference queue and bookkeeping
    logic [DATA_W-1:0] model_q [$];
    int                checks;
    int                errors;
    int                wr_accepts;
    int                rd_accepts;
    logic              pend_valid;
    logic [DATA_W-1:0] pend_data;
    logic [31:0]       lfsr_state = 32'h03645c26;

    gray_fifo #(
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_W),
        .N_SYNC     (N_SYNC),
        .WR_MARGIN  (WR_MARGIN),
        .RD_MARGIN  (RD_MARGIN),
        .REGISTERED (REGISTERED)
    ) gray_fifo_i (.*);

    initial begin
        wr_clk = 1'b0;
        forever #10 wr_clk = ~wr_clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    // One LFSR step per bit, LSB taken first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
        end
        return val;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Models the coming edge from the strobes and the flags before it
    task automatic observe_edge();
        logic wr_ok;
        logic rd_ok;
        wr_ok = i_write && !o_full;
        rd_ok = i_read && !o_empty;
        // Registered read shows the popped word one edge later
        if (pend_valid) begin
            check("o_rd_data", o_rd_data, pend_data);
            pend_valid = 1'b0;
        end
        if (rd_ok) begin
            rd_accepts++;
            if (model_q.size() == 0) begin
                errors++;
                $display("A read was accepted while the model queue was empty");
            end else begin
                if (REGISTERED == 0) begin
                    check("o_rd_data", o_rd_data, model_q[0]);
                end else begin
                    pend_valid = 1'b1;
                    pend_data  = model_q[0];
                end
                void'(model_q.pop_front());
            end
        end
        if (wr_ok) begin
            wr_accepts++;
            model_q.push_back(i_wr_data);
        end
    endtask

    // Strobes set here take effect on the next edge
    task automatic drive_cycle(input logic wr, input logic rd, input logic [DATA_W-1:0] data);
        @(posedge wr_clk);
        i_write   <= wr;
        i_read    <= rd;
        i_wr_data <= data;
        @(negedge wr_clk);
        observe_edge();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0, '0);
    endtask

    task automatic drain_fifo();
        int n;
        n = 0;
        while (model_q.size() != 0 && n < DRAIN_MAX) begin
            drive_cycle(1'b0, 1'b1, '0);
            n++;
        end
        if (model_q.size() != 0) begin
            errors++;
            $display("Draining left %0d words in the FIFO", model_q.size());
        end
        idle_cycles(SETTLE);
    endtask

    // Flags against the occupancy once the pointers have crossed
    task automatic check_settled_flags();
        int occ;
        occ = model_q.size();
        check("o_almost_full", o_almost_full, occ >= DEPTH - WR_MARGIN);
        check("o_almost_empty", o_almost_empty, occ <= RD_MARGIN);
        check("o_full", o_full, occ == DEPTH);
        check("o_empty", o_empty, occ == 0);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int   wr_base;
        int   rd_base;
        int   lat;
        int   blen;
        logic wr;
        logic rd;
        rd_rst_n   = 1'b0;
        i_write    = 1'b0;
        i_read     = 1'b0;
        i_wr_data  = '0;
        pend_valid = 1'b0;
        pend_data  = '0;
        checks     = 0;
        errors     = 0;
        wr_accepts = 0;
        rd_accepts = 0;
        repeat (RST_CYC) @(posedge wr_clk);
        rd_rst_n <= 1'b1;
        @(negedge wr_clk);

        // Reset values
        check("o_full", o_full, 0);
        check("o_almost_full", o_almost_full, 0);
        check("o_empty", o_empty, 1);
        check("o_almost_empty", o_almost_empty, 1);
        check("o_rd_data", o_rd_data, 0);

        // Random strobes, order checked on every pop
        rd_base = rd_accepts;
        repeat (RAND_CYC) begin
            wr = take_bits(1) != 0;
            rd = take_bits(1) != 0;
            drive_cycle(wr, rd, DATA_W'(take_bits(DATA_W)));
        end
        if (rd_accepts == rd_base) begin
            errors++;
            $display("No read was accepted during the random traffic");
        end
        drain_fifo();

        // Fill past full, extra writes must be dropped
        wr_base = wr_accepts;
        repeat (DEPTH + 4) drive_cycle(1'b1, 1'b0, DATA_W'(take_bits(DATA_W)));
        check("accepted writes", wr_accepts - wr_base, DEPTH);
        check("o_full", o_full, 1);
        rd_base = rd_accepts;
        drain_fifo();
        check("accepted reads", rd_accepts - rd_base, DEPTH);

        // Empty flag latency for one write
        drive_cycle(1'b1, 1'b0, DATA_W'(take_bits(DATA_W)));
        lat = 0;
        do begin
            idle_cycles(1);
            lat++;
        end while (o_empty && lat < LAT_MAX);
        // Count edges after the accepting one
        check("o_empty latency", lat - 1, N_SYNC + 1);
        drain_fifo();

        // Reads on an empty FIFO
        rd_base = rd_accepts;
        repeat (6) drive_cycle(1'b0, 1'b1, '0);
        check("reads while empty", rd_accepts - rd_base, 0);
        check("o_empty", o_empty, 1);
        // A moved read pointer would misalign this word
        drive_cycle(1'b1, 1'b0, DATA_W'(take_bits(DATA_W)));
        idle_cycles(SETTLE);
        drain_fifo();

        // Bursts of random length, then settle and compare
        for (int r = 0; r < ROUNDS; r++) begin
            blen = take_bits(4) + 1;
            repeat (blen) begin
                // Even rounds lean to writes, odd rounds to reads
                wr = (r % 2 == 0) ? take_bits(2) != 0 : take_bits(2) == 0;
                rd = (r % 2 == 0) ? take_bits(2) == 0 : take_bits(2) != 0;
                drive_cycle(wr, rd, DATA_W'(take_bits(DATA_W)));
            end
            idle_cycles(SETTLE);
            check_settled_flags();
        end

        errors += gray_fifo_i.u_props.fail_cnt;
        $display("checks %0d errors %0d assertion failures %0d",
                 checks, errors, gray_fifo_i.u_props.fail_cnt);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog with twice the nominal run time
    initial begin
        #(TOTAL_CYC * 40);
        $display("Watchdog expired before the test sequence finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : gray_fifo_tb

/* project.f */
design/fifo_pkg.sv
design/ptr_counter.sv
design/ptr_sync.sv
design/fifo_flags.sv
design/fifo_mem.sv
design/gray_fifo.sv
dv/gray_fifo_properties.sv
dv/gray_fifo_tb.sv

/* Bender.yml */
package:
  name: gray_fifo

sources:
  # RTL in compile order
  - design/fifo_pkg.sv
  - design/ptr_counter.sv
  - design/ptr_sync.sv
  - design/fifo_flags.sv
  - design/fifo_mem.sv
  - design/gray_fifo.sv
  # Verification sources
  - target: test
    files:
      - dv/gray_fifo_properties.sv
      - dv/gray_fifo_tb.sv
